//--- design/cpu_cfg.svh
// Core configuration macros for data width, register count, address width and reset PC
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ######################################################################
// Datapath
// ######################################################################

// Signed data word, also the instruction width
`define CPU_DATA_W 16

// Architectural registers
`define CPU_REG_CNT 16

// ######################################################################
// Memory map
// ######################################################################

// Byte address width on both memory ports
`define CPU_ADDR_W 16

// First instruction address, also base of the data region
`define CPU_PC_RESET 16'h1000

`endif

//--- design/isa_pkg.sv
// Instruction set types: data word, register index, opcodes and instruction layout
`include "cpu_cfg.svh"

package isa_pkg;

    // Signed register and memory word
    typedef logic signed [`CPU_DATA_W-1:0] word_t;

    // Register index wide enough for the whole file
    typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;

    // Major opcodes, func picks the variant for 0 and 1
    typedef enum logic [2:0] {
        OP_ADD_SUB  = 3'd0,
        OP_SLT_MULT = 3'd1,
        OP_LOAD     = 3'd2,
        OP_STORE    = 3'd3,
        OP_BOE      = 3'd4,
        OP_JUMP     = 3'd5
    } opcode_t;

    // R layout, the I and J forms reuse the low bits
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     func;
    } inst_t;

    // Signed 5-bit immediate from {rd, func}, widened to a word
    function automatic word_t imm_of(inst_t i);
        logic signed [4:0] imm;
        imm = {i.rd, i.func};
        return word_t'(imm);
    endfunction

endpackage

//--- design/mem_pkg.sv
// Memory types: byte address, data region base and the data request bundle
`include "cpu_cfg.svh"

package mem_pkg;

    // Byte address on both memory ports
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // Data words live above this base
    localparam addr_t DATA_BASE = `CPU_PC_RESET;

    // One data memory access, held stable for the whole handshake
    typedef struct packed {
        logic           we;
        addr_t          addr;
        isa_pkg::word_t wdata;
    } dmem_req_t;

endpackage

//--- design/mem_req_port.sv
// Four-phase req/ack requester with a type-parameterized request payload
`timescale 1ns/1ps

module mem_req_port #(
    parameter type payload_t = logic
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  payload_t       payload,
    output logic           done,
    output isa_pkg::word_t rdata,
    output logic           req,
    output payload_t       req_payload,
    input  logic           ack,
    input  isa_pkg::word_t ack_rdata
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_REQ,
        P_RELEASE
    } port_state_t;

    port_state_t state;

    // Handshake sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= P_IDLE;
            req         <= 1'b0;
            done        <= 1'b0;
            req_payload <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (start) begin
                        req_payload <= payload;
                        req         <= 1'b1;
                        state       <= P_REQ;
                    end
                end
                P_REQ: begin
                    // Responder data is valid while ack is high
                    if (ack) begin
                        req   <= 1'b0;
                        state <= P_RELEASE;
                    end
                end
                P_RELEASE: begin
                    if (!ack) begin
                        done  <= 1'b1;
                        state <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Read data captured on the ack edge
    always_ff @(posedge clk) begin
        if (state == P_REQ && ack) begin
            rdata <= ack_rdata;
        end
    end

    a_req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> $past(ack));

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (state == P_IDLE && !done));

endmodule

//--- design/reg_file.sv
// Sixteen-entry signed register file, two combinational reads and one write
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_idx_t  rs_idx,
    input  isa_pkg::reg_idx_t  rt_idx,
    output isa_pkg::word_t     rs_val,
    output isa_pkg::word_t     rt_val,
    input  logic               wr_en,
    input  isa_pkg::reg_idx_t  wr_idx,
    input  isa_pkg::word_t     wr_data
);

    localparam int REG_CNT = 2 ** $bits(isa_pkg::reg_idx_t);

    isa_pkg::word_t regs [REG_CNT];

    // All registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_idx));

endmodule

//--- design/execute_unit.sv
// ALU, next-PC selection for BOE and JUMP, and load/store address generation
`timescale 1ns/1ps

module execute_unit (
    input  isa_pkg::inst_t  inst,
    input  mem_pkg::addr_t  pc,
    input  isa_pkg::word_t  rs_val,
    input  isa_pkg::word_t  rt_val,
    output isa_pkg::word_t  result,
    output mem_pkg::addr_t  next_pc,
    output mem_pkg::addr_t  data_addr
);

    isa_pkg::word_t imm;
    isa_pkg::word_t addr_sum;
    mem_pkg::addr_t pc_seq;
    mem_pkg::addr_t branch_off;

    assign imm = isa_pkg::imm_of(inst);

    // ######################################################################
    // ALU
    // ######################################################################

    always_comb begin
        result = '0;
        case (inst.opcode)
            isa_pkg::OP_ADD_SUB: begin
                result = inst.func ? rs_val - rt_val : rs_val + rt_val;
            end
            isa_pkg::OP_SLT_MULT: begin
                // Low half of the product only
                if (inst.func) begin
                    result = rs_val * rt_val;
                end else begin
                    result = (rs_val < rt_val) ? isa_pkg::word_t'(1) : '0;
                end
            end
            default: result = '0;
        endcase
    end

    // ######################################################################
    // Next PC and data address
    // ######################################################################

    assign pc_seq     = pc + mem_pkg::addr_t'(2);
    assign branch_off = mem_pkg::addr_t'(imm) << 1;

    always_comb begin
        next_pc = pc_seq;
        if (inst.opcode == isa_pkg::OP_BOE && rs_val == rt_val) begin
            next_pc = pc_seq + branch_off;
        end else if (inst.opcode == isa_pkg::OP_JUMP) begin
            // 13-bit target, zero-extended
            next_pc = mem_pkg::addr_t'(inst[12:0]);
        end
    end

    // Word index scaled to bytes above the data base
    assign addr_sum  = rs_val + imm;
    assign data_addr = (mem_pkg::addr_t'(addr_sum) << 1) + mem_pkg::DATA_BASE;

endmodule

//--- design/core_ctrl.sv
// Stage sequencer with PC, instruction and operand registers, write-back select and io_stall
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module core_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    output logic               io_stall,
    output logic               fetch_start,
    input  logic               fetch_done,
    input  isa_pkg::word_t     fetch_word,
    output mem_pkg::addr_t     pc,
    output logic               data_start,
    input  logic               data_done,
    input  isa_pkg::word_t     data_word,
    output mem_pkg::dmem_req_t data_req,
    output isa_pkg::inst_t     inst,
    output isa_pkg::word_t     rs_val_q,
    output isa_pkg::word_t     rt_val_q,
    input  isa_pkg::word_t     rs_val,
    input  isa_pkg::word_t     rt_val,
    input  isa_pkg::word_t     result,
    input  mem_pkg::addr_t     next_pc,
    input  mem_pkg::addr_t     data_addr,
    output logic               wr_en,
    output isa_pkg::reg_idx_t  wr_idx,
    output isa_pkg::word_t     wr_data
);

    typedef enum logic [2:0] {
        S_START,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB,
        S_RETIRE
    } stage_t;

    stage_t state;
    stage_t state_nxt;
    logic   is_load;
    logic   is_mem_op;
    logic   is_alu;
    logic   retire;

    assign is_load   = inst.opcode == isa_pkg::OP_LOAD;
    assign is_mem_op = is_load || inst.opcode == isa_pkg::OP_STORE;
    assign is_alu    = inst.opcode == isa_pkg::OP_ADD_SUB ||
                       inst.opcode == isa_pkg::OP_SLT_MULT;

    // ######################################################################
    // Stage sequence
    // ######################################################################

    always_comb begin
        state_nxt = state;
        case (state)
            S_START:  state_nxt = S_FETCH;
            S_FETCH:  state_nxt = fetch_done ? S_DECODE : S_FETCH;
            S_DECODE: state_nxt = S_EXEC;
            S_EXEC: begin
                // BOE and JUMP finish here
                if (is_mem_op) begin
                    state_nxt = S_MEM;
                end else if (is_alu) begin
                    state_nxt = S_WB;
                end else begin
                    state_nxt = S_RETIRE;
                end
            end
            S_MEM:    state_nxt = data_done ? S_RETIRE : S_MEM;
            S_WB:     state_nxt = S_RETIRE;
            S_RETIRE: state_nxt = S_START;
            default:  state_nxt = S_START;
        endcase
    end

    assign retire = (state != S_RETIRE) && (state_nxt == S_RETIRE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_START;
            io_stall <= 1'b1;
            pc       <= `CPU_PC_RESET;
        end else begin
            state    <= state_nxt;
            io_stall <= !retire;
            if (state == S_EXEC) begin
                pc <= next_pc;
            end
        end
    end

    // Instruction and operand registers
    always_ff @(posedge clk) begin
        if (state == S_FETCH && fetch_done) begin
            inst <= isa_pkg::inst_t'(fetch_word);
        end
        if (state == S_DECODE) begin
            rs_val_q <= rs_val;
            rt_val_q <= rt_val;
        end
    end

    // ######################################################################
    // Memory starts and write-back
    // ######################################################################

    assign fetch_start = state == S_START;
    assign data_start  = state == S_EXEC && is_mem_op;

    assign data_req = '{
        we:    inst.opcode == isa_pkg::OP_STORE,
        addr:  data_addr,
        wdata: rt_val_q
    };

    // LOAD writes rt on its done cycle, ALU ops write rd
    assign wr_en   = (state == S_WB) || (state == S_MEM && data_done && is_load);
    assign wr_idx  = is_load ? inst.rt : inst.rd;
    assign wr_data = is_load ? data_word : result;

    a_stall_only_on_retire: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(io_stall) |-> state == S_RETIRE &&
            ($past(state) == S_EXEC || $past(state) == S_MEM || $past(state) == S_WB));

    a_stall_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !io_stall |=> io_stall);

endmodule

//--- design/cpu_core.sv
// Processor top level: sequencer, register file, execute unit and two memory ports
`timescale 1ns/1ps

module cpu_core (
    input  logic           clk,
    input  logic           rst_n,
    output logic           io_stall,
    // Instruction memory
    output logic           imem_req,
    output mem_pkg::addr_t imem_addr,
    input  logic           imem_ack,
    input  isa_pkg::word_t imem_rdata,
    // Data memory
    output logic           dmem_req,
    output logic           dmem_we,
    output mem_pkg::addr_t dmem_addr,
    output isa_pkg::word_t dmem_wdata,
    input  logic           dmem_ack,
    input  isa_pkg::word_t dmem_rdata
);

    mem_pkg::addr_t     pc;
    mem_pkg::addr_t     next_pc;
    mem_pkg::addr_t     data_addr;
    isa_pkg::inst_t     inst;
    isa_pkg::word_t     rs_val;
    isa_pkg::word_t     rt_val;
    isa_pkg::word_t     rs_val_q;
    isa_pkg::word_t     rt_val_q;
    isa_pkg::word_t     result;
    isa_pkg::word_t     wr_data;
    isa_pkg::word_t     fetch_word;
    isa_pkg::word_t     data_word;
    isa_pkg::reg_idx_t  wr_idx;
    mem_pkg::dmem_req_t data_req;
    mem_pkg::dmem_req_t dmem_bus;
    logic               fetch_start;
    logic               fetch_done;
    logic               data_start;
    logic               data_done;
    logic               wr_en;

    // ######################################################################
    // Control and datapath
    // ######################################################################

    core_ctrl u_core_ctrl (
        .clk(clk), .rst_n(rst_n), .io_stall(io_stall),
        .fetch_start(fetch_start), .fetch_done(fetch_done), .fetch_word(fetch_word),
        .pc(pc), .data_start(data_start), .data_done(data_done),
        .data_word(data_word), .data_req(data_req), .inst(inst),
        .rs_val_q(rs_val_q), .rt_val_q(rt_val_q), .rs_val(rs_val), .rt_val(rt_val),
        .result(result), .next_pc(next_pc), .data_addr(data_addr),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    // Operand indices come straight from the instruction register
    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs_idx(inst.rs), .rt_idx(inst.rt), .rs_val(rs_val), .rt_val(rt_val),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    execute_unit u_execute_unit (
        .inst(inst), .pc(pc), .rs_val(rs_val_q), .rt_val(rt_val_q),
        .result(result), .next_pc(next_pc), .data_addr(data_addr)
    );

    // ######################################################################
    // Memory ports
    // ######################################################################

    mem_req_port #(.payload_t(mem_pkg::addr_t)) u_imem_port (
        .clk(clk), .rst_n(rst_n), .start(fetch_start), .payload(pc),
        .done(fetch_done), .rdata(fetch_word), .req(imem_req),
        .req_payload(imem_addr), .ack(imem_ack), .ack_rdata(imem_rdata)
    );

    mem_req_port #(.payload_t(mem_pkg::dmem_req_t)) u_dmem_port (
        .clk(clk), .rst_n(rst_n), .start(data_start), .payload(data_req),
        .done(data_done), .rdata(data_word), .req(dmem_req),
        .req_payload(dmem_bus), .ack(dmem_ack), .ack_rdata(dmem_rdata)
    );

    // Request bundle out onto the loose data port
    assign dmem_we    = dmem_bus.we;
    assign dmem_addr  = dmem_bus.addr;
    assign dmem_wdata = dmem_bus.wdata;

endmodule

//--- testbench/tb_mem_model.sv
// Four-phase instruction and data memory responders with random ack delay
`timescale 1ns/1ps

module tb_mem_model (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           imem_req,
    input  mem_pkg::addr_t imem_addr,
    output logic           imem_ack,
    output isa_pkg::word_t imem_rdata,
    input  logic           dmem_req,
    input  logic           dmem_we,
    input  mem_pkg::addr_t dmem_addr,
    input  isa_pkg::word_t dmem_wdata,
    output logic           dmem_ack,
    output isa_pkg::word_t dmem_rdata
);

    // Word arrays indexed by byte address bits 15:1
    isa_pkg::word_t prog_mem [0:32767];
    isa_pkg::word_t data_mem [0:32767];
    integer         seed;

    initial begin
        seed       = 32'h2132_b871;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
    end

    // Every word gets a value tied to its own address
    task automatic fill_memories();
        for (int i = 0; i < 32768; i++) begin
            prog_mem[i] = 16'(i) ^ 16'hb00f;
            data_mem[i] = 16'(i) ^ 16'h3c5a;
        end
    endtask

    task automatic program_word(mem_pkg::addr_t addr, isa_pkg::word_t word);
        prog_mem[addr[15:1]] = word;
    endtask

    task automatic preload_data(mem_pkg::addr_t addr, isa_pkg::word_t word);
        data_mem[addr[15:1]] = word;
    endtask

    // One to four cycles
    function automatic int next_ack_delay();
        return 1 + ($random(seed) & 3);
    endfunction

    // ######################################################################
    // Responders
    // ######################################################################

    always begin
        @(posedge clk);
        #1;
        if (rst_n && imem_req && !imem_ack) begin
            repeat (next_ack_delay()) @(posedge clk);
            #1;
            imem_rdata = prog_mem[imem_addr[15:1]];
            imem_ack   = 1'b1;
            // Hold ack until the requester lets go
            while (imem_req) begin
                @(posedge clk);
                #1;
            end
            imem_ack = 1'b0;
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (rst_n && dmem_req && !dmem_ack) begin
            repeat (next_ack_delay()) @(posedge clk);
            #1;
            if (dmem_we) begin
                data_mem[dmem_addr[15:1]] = dmem_wdata;
            end
            dmem_rdata = data_mem[dmem_addr[15:1]];
            dmem_ack   = 1'b1;
            while (dmem_req) begin
                @(posedge clk);
                #1;
            end
            dmem_ack = 1'b0;
        end
    end

endmodule

//--- testbench/tb_cpu_core.sv
// Testbench top with clock, reset, program table, retirement checks and watchdog
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int ROW_CNT      = 21;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 40;
    localparam mem_pkg::dmem_req_t NO_WRITE = '0;

    logic           clk;
    logic           rst_n;
    logic           io_stall;
    logic           imem_req;
    logic           imem_ack;
    logic           dmem_req;
    logic           dmem_we;
    logic           dmem_ack;
    mem_pkg::addr_t imem_addr;
    mem_pkg::addr_t dmem_addr;
    isa_pkg::word_t imem_rdata;
    isa_pkg::word_t dmem_wdata;
    isa_pkg::word_t dmem_rdata;

    // Expected fetch address and data write of each retired instruction
    string              row_name  [ROW_CNT];
    mem_pkg::addr_t     row_fetch [ROW_CNT];
    mem_pkg::dmem_req_t row_write [ROW_CNT];
    int                 row_cnt;
    int                 errors;
    int                 tests_bad;
    int                 pulses;
    logic               imem_prev;
    logic               dmem_prev;

    cpu_core u_dut (
        .clk(clk), .rst_n(rst_n), .io_stall(io_stall),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata), .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_ack(dmem_ack),
        .dmem_rdata(dmem_rdata)
    );

    tb_mem_model u_mem (
        .clk(clk), .rst_n(rst_n),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata), .dmem_req(dmem_req), .dmem_we(dmem_we),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_ack(dmem_ack),
        .dmem_rdata(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Low cycles of io_stall after reset, one per retirement
    always @(negedge clk) begin
        if (!rst_n) begin
            pulses = 0;
        end else if (!io_stall) begin
            pulses++;
        end
    end

    // ######################################################################
    // Instruction encoding and table
    // ######################################################################

    function automatic isa_pkg::word_t alu_word(isa_pkg::opcode_t op, int rs, int rt, int rd,
                                                int func);
        return {op, 4'(rs), 4'(rt), 4'(rd), 1'(func)};
    endfunction

    // LOAD, STORE and BOE keep a signed 5-bit immediate in the low bits
    function automatic isa_pkg::word_t imm_word(isa_pkg::opcode_t op, int rs, int rt, int imm);
        return {op, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    function automatic isa_pkg::word_t jump_word(int target);
        return {isa_pkg::OP_JUMP, 13'(target)};
    endfunction

    function automatic mem_pkg::dmem_req_t store_to(int addr, int data);
        mem_pkg::dmem_req_t w;
        w.we    = 1'b1;
        w.addr  = 16'(addr);
        w.wdata = 16'(data);
        return w;
    endfunction

    task automatic add_row(int fetch, string name, isa_pkg::word_t code,
                           mem_pkg::dmem_req_t wr);
        row_name[row_cnt]  = name;
        row_fetch[row_cnt] = 16'(fetch);
        row_write[row_cnt] = wr;
        u_mem.program_word(16'(fetch), code);
        row_cnt++;
    endtask

    task automatic build_table();
        // Data words 1 to 3
        u_mem.preload_data(16'h1002, 16'h0007);
        u_mem.preload_data(16'h1004, 16'hfffd);
        u_mem.preload_data(16'h1006, 16'h1234);
        row_cnt = 0;
        add_row('h1000, "load r1", imm_word(isa_pkg::OP_LOAD, 0, 1, 1), NO_WRITE);
        add_row('h1002, "load r2", imm_word(isa_pkg::OP_LOAD, 0, 2, 2), NO_WRITE);
        // 7 + -3
        add_row('h1004, "add r3", alu_word(isa_pkg::OP_ADD_SUB, 1, 2, 3, 0), NO_WRITE);
        add_row('h1006, "store r3", imm_word(isa_pkg::OP_STORE, 0, 3, 8),
                store_to('h1010, 'h0004));
        add_row('h1008, "sub r4", alu_word(isa_pkg::OP_ADD_SUB, 1, 2, 4, 1), NO_WRITE);
        add_row('h100a, "store r4", imm_word(isa_pkg::OP_STORE, 0, 4, 9),
                store_to('h1012, 'h000a));
        add_row('h100c, "slt true", alu_word(isa_pkg::OP_SLT_MULT, 2, 1, 4, 0), NO_WRITE);
        add_row('h100e, "store r4", imm_word(isa_pkg::OP_STORE, 0, 4, 10),
                store_to('h1014, 'h0001));
        add_row('h1010, "slt false", alu_word(isa_pkg::OP_SLT_MULT, 1, 2, 4, 0), NO_WRITE);
        add_row('h1012, "store r4", imm_word(isa_pkg::OP_STORE, 0, 4, 11),
                store_to('h1016, 'h0000));
        add_row('h1014, "mult r5", alu_word(isa_pkg::OP_SLT_MULT, 1, 2, 5, 1), NO_WRITE);
        // Base r1 = 7 plus 5
        add_row('h1016, "store r5", imm_word(isa_pkg::OP_STORE, 1, 5, 5),
                store_to('h1018, 'hffeb));
        add_row('h1018, "load r6", imm_word(isa_pkg::OP_LOAD, 0, 6, 3), NO_WRITE);
        add_row('h101a, "store r6", imm_word(isa_pkg::OP_STORE, 0, 6, 13),
                store_to('h101a, 'h1234));
        add_row('h101c, "boe not taken", imm_word(isa_pkg::OP_BOE, 1, 2, 4), NO_WRITE);
        // Skips three words
        add_row('h101e, "boe taken", imm_word(isa_pkg::OP_BOE, 3, 3, 3), NO_WRITE);
        add_row('h1026, "jump", jump_word('h1040), NO_WRITE);
        add_row('h1040, "boe backward", imm_word(isa_pkg::OP_BOE, 0, 0, -4), NO_WRITE);
        // Negative base, -3 + 15
        add_row('h103a, "store r1", imm_word(isa_pkg::OP_STORE, 2, 1, 15),
                store_to('h1018, 'h0007));
        add_row('h103c, "add r7", alu_word(isa_pkg::OP_ADD_SUB, 6, 3, 7, 0), NO_WRITE);
        add_row('h103e, "store r7", imm_word(isa_pkg::OP_STORE, 0, 7, 14),
                store_to('h101c, 'h1238));
    endtask

    // ######################################################################
    // Checks
    // ######################################################################

    task automatic flag_error(string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic compare_addr(string sig, mem_pkg::addr_t got, mem_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic verify_write(string sig, mem_pkg::dmem_req_t got, mem_pkg::dmem_req_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected we=%b addr=%h data=%h, got we=%b addr=%h data=%h",
                     $time, sig, exp.we, exp.addr, exp.wdata, got.we, got.addr, got.wdata);
            errors++;
        end
    endtask

    // Watch both request ports until io_stall drops for one retirement
    task automatic wait_retire(output mem_pkg::addr_t fetch_addr, output int fetch_cnt,
                               output mem_pkg::dmem_req_t wr, output int wr_cnt);
        fetch_addr = '0;
        fetch_cnt  = 0;
        wr         = '0;
        wr_cnt     = 0;
        do begin
            @(negedge clk);
            if (imem_req && !imem_prev) begin
                fetch_addr = imem_addr;
                fetch_cnt++;
            end
            if (dmem_req && !dmem_prev && dmem_we) begin
                wr = '{we: dmem_we, addr: dmem_addr, wdata: dmem_wdata};
                wr_cnt++;
            end
            imem_prev = imem_req;
            dmem_prev = dmem_req;
        end while (io_stall);
    endtask

    initial begin
        repeat (RESET_CYCLES + ROW_CNT * ROW_CYCLES) @(posedge clk);
        $display("Watchdog expired before all %0d instructions retired", ROW_CNT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        mem_pkg::addr_t     fetch_addr;
        mem_pkg::dmem_req_t wr;
        int                 fetch_cnt;
        int                 wr_cnt;
        int                 errs_before;

        rst_n     = 1'b0;
        errors    = 0;
        tests_bad = 0;
        imem_prev = 1'b0;
        dmem_prev = 1'b0;
        u_mem.fill_memories();
        build_table();
        if (row_cnt != ROW_CNT) begin
            flag_error($sformatf("table holds %0d rows instead of %0d", row_cnt, ROW_CNT));
        end

        // Reset levels just before release
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (io_stall !== 1'b1 || imem_req !== 1'b0 || dmem_req !== 1'b0 ||
            dmem_we !== 1'b0) begin
            flag_error("io_stall, a request or dmem_we is not at its reset level");
            tests_bad++;
            $display("test reset: mismatch");
        end else begin
            $display("test reset: ok");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < ROW_CNT; i++) begin
            errs_before = errors;
            wait_retire(fetch_addr, fetch_cnt, wr, wr_cnt);
            if (fetch_cnt != 1) begin
                flag_error($sformatf("row %0d saw %0d fetch requests", i, fetch_cnt));
            end
            if (wr_cnt > 1) begin
                flag_error($sformatf("row %0d saw %0d data writes", i, wr_cnt));
            end
            compare_addr("imem_addr", fetch_addr, row_fetch[i]);
            verify_write("dmem write", wr, row_write[i]);
            if (errors != errs_before) begin
                tests_bad++;
            end
            $display("test %0d %s: %s", i, row_name[i],
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        // The monitor counts the last pulse on the same falling edge
        @(posedge clk);
        if (pulses != ROW_CNT) begin
            flag_error($sformatf("%0d io_stall pulses for %0d rows", pulses, ROW_CNT));
        end
        $display("%0d tests, %0d mismatched, %0d io_stall pulses, %0d errors",
                 ROW_CNT + 1, tests_bad, pulses, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- cpu_core.f
+incdir+design
design/isa_pkg.sv
design/mem_pkg.sv
design/mem_req_port.sv
design/reg_file.sv
design/execute_unit.sv
design/core_ctrl.sv
design/cpu_core.sv
testbench/tb_mem_model.sv
testbench/tb_cpu_core.sv

//--- Makefile
SOURCES := $(filter-out +%,$(shell cat cpu_core.f)) design/cpu_cfg.svh

.PHONY: run clean

run: obj_dir/Vtb_cpu_core
	@out="$$(./obj_dir/Vtb_cpu_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/Vtb_cpu_core: cpu_core.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cpu_core -f cpu_core.f

clean:
	rm -rf obj_dir
